// File: matmul_acc.f
rtl/matmul_pkg.sv
rtl/matmul_cfg_regs.sv
rtl/matmul_row_buf.sv
rtl/matmul_dma.sv
rtl/matmul_mac_array.sv
rtl/matmul_top.sv
test/matmul_checker.sv
test/matmul_tb.sv

// File: rtl/matmul_cfg_regs.sv
/*
 * host register block: matrix addresses, start pulse,
 * busy flag and sticky done flag
 */
`timescale 1ns/1ps
`default_nettype none

module matmul_cfg_regs
    import matmul_pkg::*;
(
    input  wire        clk,
    input  wire        rst_n,
    input  wire        reg_wr_i,
    input  wire reg_addr_t reg_addr_i,
    input  wire word_t reg_wdata_i,
    output word_t      reg_rdata_o,
    output addr_t      a_addr_o,
    output addr_t      b_addr_o,
    output addr_t      c_addr_o,
    output logic       dma_start_o,
    input  wire        dma_done_i
);

    logic busy_q;
    logic done_q;
    logic start_req;

    // start ignored while a run is in flight
    assign start_req = reg_wr_i && (reg_addr_i == REG_CTRL) && reg_wdata_i[0] && !busy_q;

    // address registers
    always_ff @(posedge clk) begin
        if (reg_wr_i) begin
            case (reg_addr_i)
                REG_A_ADDR: a_addr_o <= reg_wdata_i;
                REG_B_ADDR: b_addr_o <= reg_wdata_i;
                REG_C_ADDR: c_addr_o <= reg_wdata_i;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy_q      <= 1'b0;
            done_q      <= 1'b0;
            dma_start_o <= 1'b0;
        end else begin
            dma_start_o <= start_req;
            if (start_req) begin
                busy_q <= 1'b1;
                done_q <= 1'b0;
            end else if (dma_done_i) begin
                busy_q <= 1'b0;
                done_q <= 1'b1;
            end
        end
    end

    // bit 0 busy, bit 1 done
    always_comb begin
        case (reg_addr_i)
            REG_A_ADDR: reg_rdata_o = a_addr_o;
            REG_B_ADDR: reg_rdata_o = b_addr_o;
            REG_C_ADDR: reg_rdata_o = c_addr_o;
            default:    reg_rdata_o = {30'd0, done_q, busy_q};
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/matmul_dma.sv
/*
 * DMA FSM: two concurrent AXI read bursts into the row buffers,
 * engine start and wait, then one AXI write burst of C
 * and the write response
 */
`timescale 1ns/1ps
`default_nettype none

module matmul_dma
    import matmul_pkg::*;
(
    input  wire        clk,
    input  wire        rst_n,
    input  wire        start_i,
    output logic       done_o,
    input  wire addr_t a_addr_i,
    input  wire addr_t b_addr_i,
    input  wire addr_t c_addr_i,

    // AR channel
    output logic       arvalid_o,
    input  wire        arready_i,
    output addr_t      araddr_o,
    output axi_len_t   arlen_o,
    output axi_id_t    arid_o,

    // R channel
    input  wire        rvalid_i,
    output logic       rready_o,
    input  wire word_t rdata_i,
    input  wire axi_id_t rid_i,
    input  wire        rlast_i,

    // AW channel
    output logic       awvalid_o,
    input  wire        awready_i,
    output addr_t      awaddr_o,
    output axi_len_t   awlen_o,

    // W channel
    output logic       wvalid_o,
    input  wire        wready_i,
    output word_t      wdata_o,
    output logic       wlast_o,

    // B channel
    input  wire        bvalid_i,
    output logic       bready_o,

    // row buffer writes
    output logic       buf_a_wr_o,
    output logic       buf_b_wr_o,
    output row_addr_t  buf_wr_addr_o,
    output row_t       buf_wr_data_o,

    // engine
    output logic       mm_start_o,
    input  wire        mm_done_i,
    input  wire acc_t [MAT_DIM*MAT_DIM-1:0] acc_i
);

    dma_state_t state_q;
    dma_state_t state_d;

    axi_id_t    ar_tag_q;
    row_addr_t  row_a_q;
    row_addr_t  row_b_q;
    logic       a_done_q;
    logic       b_done_q;
    logic [3:0] beat_q;

    logic       r_beat;
    logic       beat_a;
    logic       beat_b;
    logic       a_fin;
    logic       b_fin;
    logic       w_beat;

    // R beats only accepted in LOAD
    assign r_beat = (state_q == LOAD) && rvalid_i;
    assign beat_a = r_beat && (rid_i == ID_A);
    assign beat_b = r_beat && (rid_i == ID_B);

    // burst finished, counting this cycle's last beat
    assign a_fin = a_done_q || (beat_a && rlast_i);
    assign b_fin = b_done_q || (beat_b && rlast_i);

    assign w_beat = wvalid_o && wready_i;

    // AR payload steered by the pending tag
    assign arvalid_o = (state_q == REQ_AB);
    assign araddr_o  = (ar_tag_q == ID_B) ? b_addr_i : a_addr_i;
    assign arlen_o   = AB_LEN;
    assign arid_o    = ar_tag_q;

    assign rready_o = (state_q == LOAD);

    assign buf_a_wr_o    = beat_a;
    assign buf_b_wr_o    = beat_b;
    assign buf_wr_addr_o = (rid_i == ID_B) ? row_b_q : row_a_q;
    assign buf_wr_data_o = rdata_i;

    assign mm_start_o = (state_q == START_MM);

    assign awvalid_o = (state_q == REQ_C);
    assign awaddr_o  = c_addr_i;
    assign awlen_o   = C_LEN;

    // accumulators streamed row-major
    assign wvalid_o = (state_q == WRITE_C);
    assign wdata_o  = word_t'(acc_i[beat_q]);
    assign wlast_o  = wvalid_o && (beat_q == 4'd15);

    assign bready_o = (state_q == WAIT_B);

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (start_i) begin
                    state_d = REQ_AB;
                end
            end
            REQ_AB: begin
                // B request follows A
                if (arready_i && (ar_tag_q == ID_B)) begin
                    state_d = LOAD;
                end
            end
            LOAD: begin
                if (a_fin && b_fin) begin
                    state_d = START_MM;
                end
            end
            START_MM: state_d = WAIT_MM;
            WAIT_MM: begin
                if (mm_done_i) begin
                    state_d = REQ_C;
                end
            end
            REQ_C: begin
                if (awready_i) begin
                    state_d = WRITE_C;
                end
            end
            WRITE_C: begin
                if (w_beat && wlast_o) begin
                    state_d = WAIT_B;
                end
            end
            WAIT_B: begin
                if (bvalid_i) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q  <= IDLE;
            ar_tag_q <= ID_A;
            row_a_q  <= '0;
            row_b_q  <= '0;
            a_done_q <= 1'b0;
            b_done_q <= 1'b0;
            beat_q   <= '0;
            done_o   <= 1'b0;
        end else begin
            state_q <= state_d;
            done_o  <= (state_q == WAIT_B) && bvalid_i;

            // fresh run
            if ((state_q == IDLE) && start_i) begin
                ar_tag_q <= ID_A;
                row_a_q  <= '0;
                row_b_q  <= '0;
                a_done_q <= 1'b0;
                b_done_q <= 1'b0;
                beat_q   <= '0;
            end

            if (arvalid_o && arready_i) begin
                ar_tag_q <= ID_B;
            end

            // per-tag row counters
            if (beat_a) begin
                row_a_q  <= row_a_q + 2'd1;
                a_done_q <= a_fin;
            end
            if (beat_b) begin
                row_b_q  <= row_b_q + 2'd1;
                b_done_q <= b_fin;
            end

            if (w_beat) begin
                beat_q <= beat_q + 4'd1;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/matmul_mac_array.sv
/*
 * 4x4 outer-product engine of 16 signed multiply-accumulators,
 * one row of A and B consumed per cycle
 */
`timescale 1ns/1ps
`default_nettype none

module matmul_mac_array
    import matmul_pkg::*;
(
    input  wire       clk,
    input  wire       rst_n,
    input  wire       start_i,
    output logic      done_o,
    output row_addr_t a_row_addr_o,
    input  wire row_t a_row_i,
    input  wire row_t b_row_i,
    output acc_t [MAT_DIM*MAT_DIM-1:0] acc_o
);

    logic      active_q;
    row_addr_t k_q;
    elem_t     a_elem [MAT_DIM];
    elem_t     b_elem [MAT_DIM];

    // same row index for both buffers
    assign a_row_addr_o = k_q;

    // unpack rows, element 0 in the low byte
    always_comb begin
        for (int n = 0; n < MAT_DIM; n++) begin
            a_elem[n] = elem_t'(a_row_i[8*n +: 8]);
            b_elem[n] = elem_t'(b_row_i[8*n +: 8]);
        end
    end

    // k runs 0..3 while active
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            active_q <= 1'b0;
            k_q      <= '0;
            done_o   <= 1'b0;
        end else begin
            done_o <= active_q && (k_q == row_addr_t'(MAT_DIM - 1));
            if (start_i) begin
                active_q <= 1'b1;
                k_q      <= '0;
            end else if (active_q) begin
                k_q <= k_q + 2'd1;
                if (k_q == row_addr_t'(MAT_DIM - 1)) begin
                    active_q <= 1'b0;
                end
            end
        end
    end

    // a row k is column k of A, b row k is row k of B
    always_ff @(posedge clk) begin
        for (int i = 0; i < MAT_DIM; i++) begin
            for (int j = 0; j < MAT_DIM; j++) begin
                if (start_i) begin
                    acc_o[i*MAT_DIM + j] <= '0;
                end else if (active_q) begin
                    acc_o[i*MAT_DIM + j] <= acc_o[i*MAT_DIM + j]
                                          + acc_t'(a_elem[i]) * acc_t'(b_elem[j]);
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/matmul_pkg.sv
/*
 * shared widths, host register indices, AXI burst lengths
 * and the DMA state encoding for the matrix-multiply accelerator
 */
`default_nettype none

package matmul_pkg;

    // widths with a meaning
    typedef logic [31:0]        addr_t;
    typedef logic [31:0]        word_t;
    typedef logic signed [7:0]  elem_t;
    typedef logic signed [31:0] acc_t;
    typedef logic [31:0]        row_t;
    typedef logic [1:0]         row_addr_t;
    typedef logic [1:0]         reg_addr_t;
    typedef logic               axi_id_t;
    typedef logic [7:0]         axi_len_t;

    localparam int MAT_DIM = 4;

    // burst length minus one
    localparam axi_len_t AB_LEN = 8'd3;
    localparam axi_len_t C_LEN  = 8'd15;

    // host register map
    localparam reg_addr_t REG_A_ADDR = 2'd0;
    localparam reg_addr_t REG_B_ADDR = 2'd1;
    localparam reg_addr_t REG_C_ADDR = 2'd2;
    localparam reg_addr_t REG_CTRL   = 2'd3;

    // read tags
    localparam axi_id_t ID_A = 1'b0;
    localparam axi_id_t ID_B = 1'b1;

    typedef enum logic [2:0] {
        IDLE,
        REQ_AB,
        LOAD,
        START_MM,
        WAIT_MM,
        REQ_C,
        WRITE_C,
        WAIT_B
    } dma_state_t;

endpackage

`default_nettype wire

// File: rtl/matmul_row_buf.sv
/*
 * four-row buffer, synchronous write, combinational read
 */
`timescale 1ns/1ps
`default_nettype none

module matmul_row_buf
    import matmul_pkg::*;
(
    input  wire            clk,
    input  wire            wr_en_i,
    input  wire row_addr_t wr_addr_i,
    input  wire row_t      wr_data_i,
    input  wire row_addr_t rd_addr_i,
    output row_t           rd_data_o
);

    row_t mem [MAT_DIM];

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

    assign rd_data_o = mem[rd_addr_i];

endmodule

`default_nettype wire

// File: rtl/matmul_top.sv
/*
 * accelerator top: register block, DMA, row buffers A and B, MAC array
 */
`timescale 1ns/1ps
`default_nettype none

module matmul_top
    import matmul_pkg::*;
(
    input  wire        clk,
    input  wire        rst_n,

    // host port
    input  wire        reg_wr_i,
    input  wire reg_addr_t reg_addr_i,
    input  wire word_t reg_wdata_i,
    output word_t      reg_rdata_o,

    // AXI
    output logic       arvalid_o,
    input  wire        arready_i,
    output addr_t      araddr_o,
    output axi_len_t   arlen_o,
    output axi_id_t    arid_o,
    input  wire        rvalid_i,
    output logic       rready_o,
    input  wire word_t rdata_i,
    input  wire axi_id_t rid_i,
    input  wire        rlast_i,
    output logic       awvalid_o,
    input  wire        awready_i,
    output addr_t      awaddr_o,
    output axi_len_t   awlen_o,
    output logic       wvalid_o,
    input  wire        wready_i,
    output word_t      wdata_o,
    output logic       wlast_o,
    input  wire        bvalid_i,
    output logic       bready_o
);

    addr_t     a_addr;
    addr_t     b_addr;
    addr_t     c_addr;
    logic      dma_start;
    logic      dma_done;
    logic      buf_a_wr;
    logic      buf_b_wr;
    row_addr_t buf_wr_addr;
    row_t      buf_wr_data;
    logic      mm_start;
    logic      mm_done;
    row_addr_t row_addr;
    row_t      a_row;
    row_t      b_row;
    acc_t [MAT_DIM*MAT_DIM-1:0] acc;

    matmul_cfg_regs cfg_regs_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .reg_wr_i    (reg_wr_i),
        .reg_addr_i  (reg_addr_i),
        .reg_wdata_i (reg_wdata_i),
        .reg_rdata_o (reg_rdata_o),
        .a_addr_o    (a_addr),
        .b_addr_o    (b_addr),
        .c_addr_o    (c_addr),
        .dma_start_o (dma_start),
        .dma_done_i  (dma_done)
    );

    matmul_dma dma_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .start_i       (dma_start),
        .done_o        (dma_done),
        .a_addr_i      (a_addr),
        .b_addr_i      (b_addr),
        .c_addr_i      (c_addr),
        .arvalid_o     (arvalid_o),
        .arready_i     (arready_i),
        .araddr_o      (araddr_o),
        .arlen_o       (arlen_o),
        .arid_o        (arid_o),
        .rvalid_i      (rvalid_i),
        .rready_o      (rready_o),
        .rdata_i       (rdata_i),
        .rid_i         (rid_i),
        .rlast_i       (rlast_i),
        .awvalid_o     (awvalid_o),
        .awready_i     (awready_i),
        .awaddr_o      (awaddr_o),
        .awlen_o       (awlen_o),
        .wvalid_o      (wvalid_o),
        .wready_i      (wready_i),
        .wdata_o       (wdata_o),
        .wlast_o       (wlast_o),
        .bvalid_i      (bvalid_i),
        .bready_o      (bready_o),
        .buf_a_wr_o    (buf_a_wr),
        .buf_b_wr_o    (buf_b_wr),
        .buf_wr_addr_o (buf_wr_addr),
        .buf_wr_data_o (buf_wr_data),
        .mm_start_o    (mm_start),
        .mm_done_i     (mm_done),
        .acc_i         (acc)
    );

    // column-major A rows
    matmul_row_buf buf_a_i (
        .clk       (clk),
        .wr_en_i   (buf_a_wr),
        .wr_addr_i (buf_wr_addr),
        .wr_data_i (buf_wr_data),
        .rd_addr_i (row_addr),
        .rd_data_o (a_row)
    );

    // row-major B rows
    matmul_row_buf buf_b_i (
        .clk       (clk),
        .wr_en_i   (buf_b_wr),
        .wr_addr_i (buf_wr_addr),
        .wr_data_i (buf_wr_data),
        .rd_addr_i (row_addr),
        .rd_data_o (b_row)
    );

    matmul_mac_array mac_array_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .start_i      (mm_start),
        .done_o       (mm_done),
        .a_row_addr_o (row_addr),
        .a_row_i      (a_row),
        .b_row_i      (b_row),
        .acc_o        (acc)
    );

endmodule

`default_nettype wire

// File: test/matmul_checker.sv
/*
 * AXI handshake assertions for the accelerator top level:
 * stable requests until ready, rready held through the read bursts
 */
`timescale 1ns/1ps
`default_nettype none

module matmul_checker
    import matmul_pkg::*;
(
    input wire           clk,
    input wire           rst_n,
    input wire           arvalid_i,
    input wire           arready_i,
    input wire addr_t    araddr_i,
    input wire axi_len_t arlen_i,
    input wire axi_id_t  arid_i,
    input wire           rvalid_i,
    input wire           rready_i,
    input wire           rlast_i,
    input wire           awvalid_i,
    input wire           awready_i,
    input wire addr_t    awaddr_i,
    input wire axi_len_t awlen_i,
    input wire           wvalid_i,
    input wire           wready_i,
    input wire word_t    wdata_i,
    input wire           wlast_i
);

    int fail_count = 0;

    logic [1:0] ar_seen;
    logic [1:0] last_seen;

    // both read requests accepted, bursts not yet finished
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ar_seen   <= '0;
            last_seen <= '0;
        end else if (rvalid_i && rready_i && rlast_i && (last_seen == 2'd1)) begin
            ar_seen   <= '0;
            last_seen <= '0;
        end else begin
            if (arvalid_i && arready_i) begin
                ar_seen <= ar_seen + 2'd1;
            end
            if (rvalid_i && rready_i && rlast_i) begin
                last_seen <= last_seen + 2'd1;
            end
        end
    end

    ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
        arvalid_i && !arready_i |=> arvalid_i && $stable(araddr_i)
                                    && $stable(arlen_i) && $stable(arid_i))
        else begin
            $error("AR request dropped or changed before arready");
            fail_count++;
        end

    aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
        awvalid_i && !awready_i |=> awvalid_i && $stable(awaddr_i) && $stable(awlen_i))
        else begin
            $error("AW request dropped or changed before awready");
            fail_count++;
        end

    w_hold: assert property (@(posedge clk) disable iff (!rst_n)
        wvalid_i && !wready_i |=> wvalid_i && $stable(wdata_i) && $stable(wlast_i))
        else begin
            $error("W beat dropped or changed before wready");
            fail_count++;
        end

    r_ready: assert property (@(posedge clk) disable iff (!rst_n)
        (ar_seen == 2'd2) |-> rready_i)
        else begin
            $error("rready low while read bursts are outstanding");
            fail_count++;
        end

endmodule

bind matmul_top matmul_checker checker_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .arvalid_i (arvalid_o),
    .arready_i (arready_i),
    .araddr_i  (araddr_o),
    .arlen_i   (arlen_o),
    .arid_i    (arid_o),
    .rvalid_i  (rvalid_i),
    .rready_i  (rready_o),
    .rlast_i   (rlast_i),
    .awvalid_i (awvalid_o),
    .awready_i (awready_i),
    .awaddr_i  (awaddr_o),
    .awlen_i   (awlen_o),
    .wvalid_i  (wvalid_o),
    .wready_i  (wready_i),
    .wdata_i   (wdata_o),
    .wlast_i   (wlast_o)
);

`default_nettype wire

// File: test/matmul_tb.sv
/*
 * testbench for the matrix-multiply accelerator: host register tasks,
 * AXI memory model with random stalls and R interleave,
 * reference model, compare tasks and watchdog
 */
`timescale 1ns/1ps
`default_nettype none

module matmul_tb;
    import matmul_pkg::*;

    localparam int NUM_RUNS   = 20;
    localparam int RUN_CYCLES = 2000;
    localparam int N_C        = MAT_DIM * MAT_DIM;

    logic      clk;
    logic      rst_n;
    logic      reg_wr;
    reg_addr_t reg_addr;
    word_t     reg_wdata;
    word_t     reg_rdata;
    logic      arvalid, arready, rvalid, rready, rlast;
    addr_t     araddr, awaddr;
    axi_len_t  arlen, awlen;
    axi_id_t   arid, rid;
    word_t     rdata, wdata;
    logic      awvalid, awready, wvalid, wready, wlast, bvalid, bready;

    integer seed = 76630;
    int     value_errs = 0;
    int     proto_errs = 0;

    // memory and per-run expectations
    word_t mem [addr_t];
    addr_t run_a [NUM_RUNS];
    addr_t run_b [NUM_RUNS];
    addr_t run_c [NUM_RUNS];
    acc_t  exp_c [NUM_RUNS*N_C];
    int    run_idx;

    // memory model state
    int    ar_count, aw_count, w_count;
    int    r_left [2];
    int    r_idx [2];
    addr_t r_base [2];
    addr_t w_base;
    logic  b_pending;

    matmul_top matmul_top_i (
        .clk (clk), .rst_n (rst_n),
        .reg_wr_i (reg_wr), .reg_addr_i (reg_addr),
        .reg_wdata_i (reg_wdata), .reg_rdata_o (reg_rdata),
        .arvalid_o (arvalid), .arready_i (arready), .araddr_o (araddr),
        .arlen_o (arlen), .arid_o (arid),
        .rvalid_i (rvalid), .rready_o (rready), .rdata_i (rdata),
        .rid_i (rid), .rlast_i (rlast),
        .awvalid_o (awvalid), .awready_i (awready), .awaddr_o (awaddr), .awlen_o (awlen),
        .wvalid_o (wvalid), .wready_i (wready), .wdata_o (wdata), .wlast_o (wlast),
        .bvalid_i (bvalid), .bready_o (bready)
    );

    always #50 clk = ~clk;

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            value_errs++;
            $display("** Error %s: expected %h, got %h", name, exp, act);
        end
    endtask

    task automatic check_acc(input string name, input acc_t exp, input acc_t act);
        if (act !== exp) begin
            value_errs++;
            $display("** Error %s: expected %h, got %h", name, exp, act);
        end
    endtask

    task automatic check_addr(input string name, input addr_t exp, input addr_t act);
        if (act !== exp) begin
            value_errs++;
            $display("** Error %s: expected %h, got %h", name, exp, act);
        end
    endtask

    task automatic check_len(input string name, input axi_len_t exp, input axi_len_t act);
        if (act !== exp) begin
            value_errs++;
            $display("** Error %s: expected %h, got %h", name, exp, act);
        end
    endtask

    // called right after a rising edge
    task automatic write_reg(input reg_addr_t addr, input word_t data);
        reg_wr    <= 1'b1;
        reg_addr  <= addr;
        reg_wdata <= data;
        @(posedge clk);
        reg_wr <= 1'b0;
    endtask

    task automatic read_reg(input reg_addr_t addr, output word_t data);
        reg_addr <= addr;
        @(posedge clk);
        data = reg_rdata;
    endtask

    // matrices into memory and C[i][j] as the sum over k of A[i][k] * B[k][j]
    task automatic prepare_runs();
        elem_t a_m [MAT_DIM][MAT_DIM];
        elem_t b_m [MAT_DIM][MAT_DIM];
        acc_t  sum;
        addr_t base;
        word_t w;
        for (int r = 0; r < NUM_RUNS; r++) begin
            base     = ({$random(seed)} & 32'hFFF0_0000) | (r << 12);
            run_a[r] = base;
            run_b[r] = base + 32'h100;
            run_c[r] = base + 32'h200;
            for (int i = 0; i < MAT_DIM; i++) begin
                for (int j = 0; j < MAT_DIM; j++) begin
                    a_m[i][j] = elem_t'($random(seed));
                    b_m[i][j] = elem_t'($random(seed));
                end
            end
            // A column-major and B row-major with element 0 in the low byte
            for (int k = 0; k < MAT_DIM; k++) begin
                for (int n = 0; n < MAT_DIM; n++) begin
                    w[8*n +: 8] = a_m[n][k];
                end
                mem[addr_t'(run_a[r] + 4*k)] = w;
                for (int n = 0; n < MAT_DIM; n++) begin
                    w[8*n +: 8] = b_m[k][n];
                end
                mem[addr_t'(run_b[r] + 4*k)] = w;
            end
            for (int i = 0; i < MAT_DIM; i++) begin
                for (int j = 0; j < MAT_DIM; j++) begin
                    sum = 0;
                    for (int k = 0; k < MAT_DIM; k++) begin
                        sum = sum + acc_t'(a_m[i][k]) * acc_t'(b_m[k][j]);
                    end
                    exp_c[r*N_C + i*MAT_DIM + j] = sum;
                end
            end
        end
    endtask

    // AXI memory with random ready and valid stalls and interleaved A and B beats
    always @(posedge clk) begin : axi_mem_model
        axi_id_t t;
        logic    r_free;
        if (!rst_n) begin
            arready   <= 1'b0;
            rvalid    <= 1'b0;
            awready   <= 1'b0;
            wready    <= 1'b0;
            bvalid    <= 1'b0;
            r_left[0] = 0;
            r_left[1] = 0;
            b_pending = 1'b0;
        end else begin
            if (arvalid && arready) begin
                if (ar_count >= 2) begin
                    proto_errs++;
                    $display("run %0d: extra AR request seen", run_idx);
                end else begin
                    if (arid !== axi_id_t'(ar_count)) begin
                        proto_errs++;
                        $display("run %0d: AR request %0d has the wrong tag", run_idx, ar_count);
                    end
                    check_addr("araddr", (ar_count == 0) ? run_a[run_idx] : run_b[run_idx],
                               araddr);
                    check_len("arlen", axi_len_t'(MAT_DIM - 1), arlen);
                end
                r_base[arid] = araddr;
                r_left[arid] = MAT_DIM;
                r_idx[arid]  = 0;
                ar_count++;
            end
            arready <= ({$random(seed)} % 3) != 0;

            r_free = !rvalid || rready;
            if (rvalid && rready) begin
                r_left[rid]--;
                r_idx[rid]++;
            end
            if (r_free) begin
                rvalid <= 1'b0;
                if ((r_left[0] + r_left[1]) > 0 && ({$random(seed)} % 4) != 0) begin
                    if (r_left[ID_A] == 0) begin
                        t = ID_B;
                    end else if (r_left[ID_B] == 0) begin
                        t = ID_A;
                    end else begin
                        t = axi_id_t'($random(seed));
                    end
                    rvalid <= 1'b1;
                    rid    <= t;
                    rdata  <= mem[addr_t'(r_base[t] + 4*r_idx[t])];
                    rlast  <= (r_left[t] == 1);
                end
            end

            if (awvalid && awready) begin
                check_addr("awaddr", run_c[run_idx], awaddr);
                check_len("awlen", axi_len_t'(N_C - 1), awlen);
                w_base = awaddr;
                aw_count++;
            end
            awready <= ({$random(seed)} % 3) != 0;

            if (wvalid && wready) begin
                if (aw_count == 0 || w_count >= N_C) begin
                    proto_errs++;
                    $display("run %0d: W beat without an open write burst", run_idx);
                end else begin
                    if (wlast !== (w_count == N_C - 1)) begin
                        proto_errs++;
                        $display("run %0d: wlast wrong on W beat %0d", run_idx, w_count);
                    end
                    mem[addr_t'(w_base + 4*w_count)] = wdata;
                    w_count++;
                    b_pending = (w_count == N_C);
                end
            end
            wready <= ({$random(seed)} % 3) != 0;

            if (bvalid && bready) begin
                bvalid <= 1'b0;
            end else if (b_pending && !bvalid && ({$random(seed)} % 2) != 0) begin
                bvalid    <= 1'b1;
                b_pending = 1'b0;
            end
        end
    end

    task automatic do_run(input int r);
        word_t status;
        int    cycles;
        run_idx  = r;
        ar_count = 0;
        aw_count = 0;
        w_count  = 0;
        write_reg(REG_A_ADDR, run_a[r]);
        write_reg(REG_B_ADDR, run_b[r]);
        write_reg(REG_C_ADDR, run_c[r]);
        read_reg(REG_A_ADDR, status);
        check_word("reg_a_addr", run_a[r], status);
        read_reg(REG_B_ADDR, status);
        check_word("reg_b_addr", run_b[r], status);
        read_reg(REG_C_ADDR, status);
        check_word("reg_c_addr", run_c[r], status);

        write_reg(REG_CTRL, 32'h1);
        read_reg(REG_CTRL, status);
        check_word("reg_ctrl", 32'h1, status);
        // second start while busy must be dropped
        write_reg(REG_CTRL, 32'h1);

        cycles = 0;
        read_reg(REG_CTRL, status);
        while (!status[1] && cycles < RUN_CYCLES) begin
            if (!status[0]) begin
                proto_errs++;
                $display("run %0d: busy dropped before done", r);
                cycles = RUN_CYCLES;
            end else begin
                read_reg(REG_CTRL, status);
                cycles++;
            end
        end
        if (!status[1]) begin
            proto_errs++;
            $display("run %0d: done not seen within %0d cycles", r, RUN_CYCLES);
        end else begin
            check_word("reg_ctrl", 32'h2, status);
        end

        if (ar_count != 2 || aw_count != 1 || w_count != N_C) begin
            proto_errs++;
            $display("run %0d: saw %0d AR, %0d AW and %0d W transfers", r,
                     ar_count, aw_count, w_count);
        end
        for (int n = 0; n < N_C; n++) begin
            check_acc("wdata", exp_c[r*N_C + n], acc_t'(mem[addr_t'(run_c[r] + 4*n)]));
        end
    endtask

    initial begin : watchdog
        repeat (NUM_RUNS * RUN_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles", NUM_RUNS * RUN_CYCLES);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin : main
        word_t status;
        int    assert_errs;
        clk       = 1'b0;
        rst_n     = 1'b0;
        reg_wr    = 1'b0;
        reg_addr  = '0;
        reg_wdata = '0;
        arready   = 1'b0;
        rvalid    = 1'b0;
        rdata     = '0;
        rid       = ID_A;
        rlast     = 1'b0;
        awready   = 1'b0;
        wready    = 1'b0;
        bvalid    = 1'b0;
        run_idx   = 0;
        ar_count  = 0;
        aw_count  = 0;
        w_count   = 0;
        prepare_runs();

        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        read_reg(REG_CTRL, status);
        check_word("reg_ctrl", 32'h0, status);

        for (int r = 0; r < NUM_RUNS; r++) begin
            do_run(r);
        end

        assert_errs = matmul_top_i.checker_i.fail_count;
        $display("value errors: %0d, protocol errors: %0d, assertion errors: %0d",
                 value_errs, proto_errs, assert_errs);
        if (value_errs + proto_errs + assert_errs == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
